// ==== addressUnit.sv ====
module addressUnit (
    input  logic                          Clock,
    input  logic                          Reset,
    input  logic                          arLoadAddress,
    input  logic                          arAddOffset,
    input  logic                          arIncrement,
    input  logic                          drLoadLow,
    input  logic                          drLoadHigh,
    input  logic                          useAr,
    input  logic [cpuPkg::laneWidth-1:0]  byteLane,
    input  logic [cpuPkg::addrWidth-1:0]  pc,
    input  logic [cpuPkg::byteWidth-1:0]  immediate,
    input  logic [cpuPkg::byteWidth-1:0]  MemReadData,
    input  logic [cpuPkg::dataWidth-1:0]  selectedData,
    output logic [cpuPkg::addrWidth-1:0]  MemAddress,
    output logic [cpuPkg::byteWidth-1:0]  MemWriteData,
    output logic [cpuPkg::dataWidth-1:0]  loadData
);

    logic [cpuPkg::addrWidth-1:0]   ar;
    logic [2*cpuPkg::byteWidth-1:0] dataReg;    // Little-endian halfword
    logic [cpuPkg::byteWidth-1:0]   highByte;

    // ========================================
    // Address register
    // ========================================
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            ar <= '0;
        end else if (arLoadAddress) begin
            ar <= immediate;                    // Address field
        end else if (arAddOffset) begin
            ar <= ar + immediate;               // STRIM effective address
        end else if (arIncrement) begin
            ar <= ar + 1'b1;                    // Next byte
        end
    end

    // ========================================
    // Data register
    // ========================================
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            dataReg <= '0;
        end else begin
            if (drLoadLow) begin
                dataReg[cpuPkg::byteWidth-1:0] <= MemReadData;
            end
            if (drLoadHigh) begin
                dataReg[2*cpuPkg::byteWidth-1:cpuPkg::byteWidth] <= MemReadData;
            end
        end
    end

    // The high byte arrives in the same step that writes Rx
    assign highByte = drLoadHigh ? MemReadData
                                 : dataReg[2*cpuPkg::byteWidth-1:cpuPkg::byteWidth];
    assign loadData = {{(cpuPkg::dataWidth-2*cpuPkg::byteWidth){1'b0}},
                       highByte, dataReg[cpuPkg::byteWidth-1:0]};

    // ========================================
    // Memory port
    // ========================================
    assign MemAddress   = useAr ? ar : pc;
    assign MemWriteData = selectedData[byteLane*cpuPkg::byteWidth +: cpuPkg::byteWidth];

endmodule

// ==== cpuPkg.sv ====
package cpuPkg;

    // ========================================
    // Widths
    // ========================================
    localparam int dataWidth   = 32;            // General register width
    localparam int byteWidth   = 8;             // Memory data width
    localparam int addrWidth   = 8;             // Memory address width
    localparam int opcodeWidth = 6;
    localparam int regSelWidth = 2;

    localparam int bytesPerWord = 4;            // Bytes per register store
    localparam int laneWidth    = 2;            // Index of a byte within a word

    // ========================================
    // Encodings
    // ========================================
    // Opcode values follow the original instruction set
    typedef enum logic [opcodeWidth-1:0] {
        MOVSH = 6'h1A,
        LDAL  = 6'h1E,
        STA   = 6'h20,
        STRIM = 6'h24
    } opcodeT;

    typedef enum logic [2:0] {
        stepFetchLow,                           // T0
        stepFetchHigh,                          // T1
        stepDecode,                             // T2
        stepExec1,
        stepExec2,
        stepExec3,
        stepExec4,
        stepExec5                               // T7
    } stepT;

    // ========================================
    // Cycles per instruction
    // ========================================
    // Counted from stepFetchLow to the last step, inclusive
    localparam int cyclesNop   = 3;             // Ends at decode
    localparam int cyclesMovsh = 4;
    localparam int cyclesLdal  = 6;             // High byte read and Rx write share a step
    localparam int cyclesSta   = 8;
    localparam int cyclesStrim = 8;             // One add step, then four byte writes

endpackage

// ==== cpuTbProgram.svh ====
`ifndef CPU_TB_PROGRAM_SVH
`define CPU_TB_PROGRAM_SVH

// Each row holds the test name, instruction, cycles, write count, first write address
// and the register word expected in the store, lane 0 landing at the first address
task automatic buildProgramTable();
    addRow("unknownNop", encodeInstr(6'h3F, 2'd0, 8'h55),
           cpuPkg::cyclesNop, 0, 8'h00, 32'h0000_0000);
    addRow("staR3Reset", encodeInstr(cpuPkg::STA, 2'd2, 8'hA0),
           cpuPkg::cyclesSta, cpuPkg::bytesPerWord, 8'hA0, 32'h0000_0000);
    addRow("movshR1First", encodeInstr(cpuPkg::MOVSH, 2'd0, 8'h12),
           cpuPkg::cyclesMovsh, 0, 8'h00, 32'h0000_0000);
    addRow("movshR1Second", encodeInstr(cpuPkg::MOVSH, 2'd0, 8'h34),
           cpuPkg::cyclesMovsh, 0, 8'h00, 32'h0000_0000);
    addRow("staR1", encodeInstr(cpuPkg::STA, 2'd0, 8'h80),
           cpuPkg::cyclesSta, cpuPkg::bytesPerWord, 8'h80, 32'h0000_1234);
    // AR left at 0x84 by the store above
    addRow("strimR1", encodeInstr(cpuPkg::STRIM, 2'd0, 8'h08),
           cpuPkg::cyclesStrim, cpuPkg::bytesPerWord, 8'h8C, 32'h0000_1234);
    addRow("ldalR2", encodeInstr(cpuPkg::LDAL, 2'd1, 8'h90),
           cpuPkg::cyclesLdal, 0, 8'h00, 32'h0000_0000);
    addRow("staR2", encodeInstr(cpuPkg::STA, 2'd1, 8'h98),
           cpuPkg::cyclesSta, cpuPkg::bytesPerWord, 8'h98, 32'h0000_ABCD);
endtask

// Halfword for ldalR2, low byte first
task automatic placeDataBytes();
    mem[8'h90] = 8'hCD;
    mem[8'h91] = 8'hAB;
endtask

`endif

// ==== cpuTb.sv ====
module cpuTb;

    localparam int randomSeed  = 14;
    localparam int memDepth    = 2**cpuPkg::addrWidth;
    localparam int resetCycles = 8;
    localparam int slackCycles = 20;                    // Margin over the program length

    logic                         Clock;
    logic                         Reset;
    logic [cpuPkg::byteWidth-1:0] MemReadData;
    logic [cpuPkg::addrWidth-1:0] MemAddress;
    logic                         MemEnable;
    logic                         MemWrite;
    logic [cpuPkg::byteWidth-1:0] MemWriteData;

    logic [cpuPkg::byteWidth-1:0] mem [memDepth];       // Byte memory model

    // ========================================
    // Test table and expected writes
    // ========================================
    string       rowName   [$];
    logic [15:0] rowInstr  [$];
    int          rowCycles [$];
    int          rowWrites [$];
    logic [7:0]  rowAddr   [$];
    logic [31:0] rowWord   [$];                         // Register value the store writes out
    int          startCycle [$];                        // One more entry for the program end
    string       expName [$];
    logic [7:0]  expAddr [$];
    logic [7:0]  expData [$];
    int          cycle;
    int          writeIndex;
    int          cycleLimit;
    bit          programDone;

    cpuTop dut_i (
        .Clock        (Clock),
        .Reset        (Reset),
        .MemReadData  (MemReadData),
        .MemAddress   (MemAddress),
        .MemEnable    (MemEnable),
        .MemWrite     (MemWrite),
        .MemWriteData (MemWriteData)
    );

    always #5 Clock = ~Clock;

    assign MemReadData = mem[MemAddress];               // Answer in the same cycle

    always @(posedge Clock) begin
        if (MemEnable && MemWrite) begin
            mem[MemAddress] <= MemWriteData;
        end
    end

    // Opcode in bits 15 to 10, Rx in 9 to 8, address or offset below
    function automatic logic [15:0] encodeInstr(input logic [5:0] op, input logic [1:0] rx,
                                                input logic [7:0] imm);
        return {op, rx, imm};
    endfunction

    task automatic addRow(input string name, input logic [15:0] instr, input int cycles,
                          input int writes, input logic [7:0] firstAddr, input logic [31:0] word);
        rowName.push_back(name);
        rowInstr.push_back(instr);
        rowCycles.push_back(cycles);
        rowWrites.push_back(writes);
        rowAddr.push_back(firstAddr);
        rowWord.push_back(word);
    endtask

`include "cpuTbProgram.svh"

    task automatic buildExpectedWrites();
        int          start;
        logic [31:0] word;
        start = 0;
        for (int k = 0; k < rowName.size(); k++) begin
            startCycle.push_back(start);
            start += rowCycles[k];
            word = rowWord[k];
            for (int i = 0; i < rowWrites[k]; i++) begin
                expName.push_back(rowName[k]);
                expAddr.push_back(rowAddr[k] + 8'(i));  // AR steps one byte per write
                expData.push_back(word[8*i +: 8]);      // Little-endian lanes
            end
        end
        startCycle.push_back(start);
        cycleLimit = start + slackCycles;
    endtask

    task automatic loadMemory();
        for (int a = 0; a < memDepth; a++) begin
            mem[8'(a)] = 8'($urandom);
        end
        for (int k = 0; k < rowName.size(); k++) begin
            mem[8'(2*k)]   = rowInstr[k][7:0];          // Low byte first
            mem[8'(2*k+1)] = rowInstr[k][15:8];
        end
        placeDataBytes();
    endtask

    task automatic stopOnError();
        $display("Errors found");
        $fatal(1);
    endtask

    // ========================================
    // Per-cycle checks at the falling edge
    // ========================================
    task automatic checkCycle();
        string name;
        assert (!$isunknown(MemEnable) && !$isunknown(MemWrite)) else begin
            $display("Memory strobes are unknown at cycle %0d", cycle);
            stopOnError();
        end
        for (int k = 0; k < startCycle.size(); k++) begin
            name = (k < rowName.size()) ? rowName[k] : "programEnd";
            if (cycle == startCycle[k]) begin
                assert (MemEnable && !MemWrite && MemAddress == 8'(2*k)) else begin
                    $display("error %s: expected fetch at %h, actual address %h en %b wr %b",
                             name, 8'(2*k), MemAddress, MemEnable, MemWrite);
                    stopOnError();
                end
            end
        end
        if (MemEnable && !MemWrite && MemAddress == 8'(2*rowName.size())) begin
            programDone = 1'b1;                         // Fetch past the last instruction
        end
        if (MemEnable && MemWrite) begin
            assert (writeIndex < expAddr.size()) else begin
                $display("Unexpected write of %h to address %h after all expected stores",
                         MemWriteData, MemAddress);
                stopOnError();
            end
            assert (MemAddress == expAddr[writeIndex] && MemWriteData == expData[writeIndex])
            else begin
                $display("error %s: expected %h at %h, actual %h at %h", expName[writeIndex],
                         expData[writeIndex], expAddr[writeIndex], MemWriteData, MemAddress);
                stopOnError();
            end
            writeIndex++;
        end
    endtask

    initial begin
        bit allSeen;
        Clock       = 1'b0;
        Reset       = 1'b1;
        cycle       = 0;
        writeIndex  = 0;
        programDone = 1'b0;
        void'($urandom(randomSeed));
        buildProgramTable();
        buildExpectedWrites();
        loadMemory();

        repeat (resetCycles) @(posedge Clock);
        @(negedge Clock);
        Reset = 1'b0;

        while (!programDone) begin
            assert (cycle < cycleLimit) else begin
                $display("Timeout: the program did not finish within %0d cycles", cycleLimit);
                stopOnError();
            end
            checkCycle();
            if (!programDone) begin
                @(negedge Clock);
                cycle++;
            end
        end

        allSeen = (writeIndex == expAddr.size());
        assert (allSeen) else
            $display("Missing writes: only %0d of %0d expected stores were seen",
                     writeIndex, expAddr.size());
        if (allSeen) begin
            $display("No errors");
            $finish;
        end else begin
            stopOnError();
        end
    end

endmodule

// ==== cpuTop.sv ====
module cpuTop (
    input  logic                          Clock,
    input  logic                          Reset,
    input  logic [cpuPkg::byteWidth-1:0]  MemReadData,
    output logic [cpuPkg::addrWidth-1:0]  MemAddress,
    output logic                          MemEnable,
    output logic                          MemWrite,
    output logic [cpuPkg::byteWidth-1:0]  MemWriteData
);

    // ========================================
    // Internal wires
    // ========================================
    logic [cpuPkg::addrWidth-1:0]   pc;
    logic [2*cpuPkg::byteWidth-1:0] instruction;
    cpuPkg::opcodeT                 opcode;
    logic [cpuPkg::regSelWidth-1:0] regSel;
    logic [cpuPkg::byteWidth-1:0]   immediate;
    logic [cpuPkg::dataWidth-1:0]   selectedData;
    logic [cpuPkg::dataWidth-1:0]   loadData;
    logic [cpuPkg::laneWidth-1:0]   byteLane;

    logic irLoadLow;
    logic irLoadHigh;
    logic pcIncrement;
    logic decodeLoad;
    logic regShiftLoad;
    logic regLoadData;
    logic arLoadAddress;
    logic arAddOffset;
    logic arIncrement;
    logic drLoadLow;
    logic drLoadHigh;
    logic useAr;

    // ========================================
    // Stages
    // ========================================
    fetchStage fetch_i (
        .Clock       (Clock),
        .Reset       (Reset),
        .irLoadLow   (irLoadLow),
        .irLoadHigh  (irLoadHigh),
        .pcIncrement (pcIncrement),
        .MemReadData (MemReadData),
        .pc          (pc),
        .instruction (instruction)
    );

    decodeStage decode_i (
        .Clock       (Clock),
        .Reset       (Reset),
        .decodeLoad  (decodeLoad),
        .instruction (instruction),
        .opcode      (opcode),
        .regSel      (regSel),
        .immediate   (immediate)
    );

    sequencer sequencer_i (
        .Clock         (Clock),
        .Reset         (Reset),
        .opcode        (opcode),
        .irLoadLow     (irLoadLow),
        .irLoadHigh    (irLoadHigh),
        .pcIncrement   (pcIncrement),
        .decodeLoad    (decodeLoad),
        .regShiftLoad  (regShiftLoad),
        .regLoadData   (regLoadData),
        .arLoadAddress (arLoadAddress),
        .arAddOffset   (arAddOffset),
        .arIncrement   (arIncrement),
        .drLoadLow     (drLoadLow),
        .drLoadHigh    (drLoadHigh),
        .byteLane      (byteLane),
        .useAr         (useAr),
        .memEnable     (MemEnable),        // Straight to the memory port
        .memWrite      (MemWrite)
    );

    // ========================================
    // Datapath
    // ========================================
    registerFile regFile_i (
        .Clock        (Clock),
        .Reset        (Reset),
        .regShiftLoad (regShiftLoad),
        .regLoadData  (regLoadData),
        .regSel       (regSel),
        .immediate    (immediate),
        .loadData     (loadData),
        .selectedData (selectedData)
    );

    addressUnit addrUnit_i (
        .Clock         (Clock),
        .Reset         (Reset),
        .arLoadAddress (arLoadAddress),
        .arAddOffset   (arAddOffset),
        .arIncrement   (arIncrement),
        .drLoadLow     (drLoadLow),
        .drLoadHigh    (drLoadHigh),
        .useAr         (useAr),
        .byteLane      (byteLane),
        .pc            (pc),
        .immediate     (immediate),
        .MemReadData   (MemReadData),
        .selectedData  (selectedData),
        .MemAddress    (MemAddress),
        .MemWriteData  (MemWriteData),
        .loadData      (loadData)
    );

endmodule

// ==== decodeStage.sv ====
module decodeStage (
    input  logic                            Clock,
    input  logic                            Reset,
    input  logic                            decodeLoad,
    input  logic [2*cpuPkg::byteWidth-1:0]  instruction,
    output cpuPkg::opcodeT                  opcode,
    output logic [cpuPkg::regSelWidth-1:0]  regSel,
    output logic [cpuPkg::byteWidth-1:0]    immediate
);

    cpuPkg::opcodeT opcodeReg;                  // Held for the execute steps
    cpuPkg::opcodeT irOpcode;                   // Field straight from the IR

    assign irOpcode = cpuPkg::opcodeT'(instruction[15:10]);

    // Field latch at the end of the decode step
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            opcodeReg <= cpuPkg::opcodeT'('0);
            regSel    <= '0;
            immediate <= '0;
        end else if (decodeLoad) begin
            opcodeReg <= irOpcode;
            regSel    <= instruction[9:8];      // Rx
            immediate <= instruction[7:0];      // Address or offset
        end
    end

    // The sequencer picks the step after decode from the fresh opcode,
    // so the IR field is forwarded while the latch is being written
    assign opcode = decodeLoad ? irOpcode : opcodeReg;

endmodule

// ==== fetchStage.sv ====
module fetchStage (
    input  logic                          Clock,
    input  logic                          Reset,
    input  logic                          irLoadLow,
    input  logic                          irLoadHigh,
    input  logic                          pcIncrement,
    input  logic [cpuPkg::byteWidth-1:0]  MemReadData,
    output logic [cpuPkg::addrWidth-1:0]  pc,
    output logic [2*cpuPkg::byteWidth-1:0] instruction
);

    // ========================================
    // Program counter
    // ========================================
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            pc <= '0;                           // First fetch from address 0
        end else if (pcIncrement) begin
            pc <= pc + 1'b1;                    // Next instruction byte
        end
    end

    // ========================================
    // Instruction register
    // ========================================
    // Two byte reads build one instruction, low byte first
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            instruction <= '0;
        end else begin
            if (irLoadLow) begin
                instruction[cpuPkg::byteWidth-1:0] <= MemReadData;
            end
            if (irLoadHigh) begin
                instruction[2*cpuPkg::byteWidth-1:cpuPkg::byteWidth] <= MemReadData;
            end
        end
    end

endmodule

// ==== registerFile.sv ====
module registerFile (
    input  logic                            Clock,
    input  logic                            Reset,
    input  logic                            regShiftLoad,
    input  logic                            regLoadData,
    input  logic [cpuPkg::regSelWidth-1:0]  regSel,
    input  logic [cpuPkg::byteWidth-1:0]    immediate,
    input  logic [cpuPkg::dataWidth-1:0]    loadData,
    output logic [cpuPkg::dataWidth-1:0]    selectedData
);

    // Entry 0 is R1, entry 3 is R4
    logic [cpuPkg::dataWidth-1:0] regs [2**cpuPkg::regSelWidth];

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < 2**cpuPkg::regSelWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (regShiftLoad) begin
            // Shift up one byte, immediate enters at the bottom
            regs[regSel] <= {regs[regSel][cpuPkg::dataWidth-cpuPkg::byteWidth-1:0],
                             immediate};
        end else if (regLoadData) begin
            regs[regSel] <= loadData;           // Word from memory
        end
    end

    assign selectedData = regs[regSel];         // Rx to the store path

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module cpuTb -f verilog.f -o cpuSim

output=$(./obj_dir/cpuSim || true)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "No errors"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// ==== sequencer.sv ====
module sequencer (
    input  logic                          Clock,
    input  logic                          Reset,
    input  cpuPkg::opcodeT                opcode,
    output logic                          irLoadLow,
    output logic                          irLoadHigh,
    output logic                          pcIncrement,
    output logic                          decodeLoad,
    output logic                          regShiftLoad,
    output logic                          regLoadData,
    output logic                          arLoadAddress,
    output logic                          arAddOffset,
    output logic                          arIncrement,
    output logic                          drLoadLow,
    output logic                          drLoadHigh,
    output logic [cpuPkg::laneWidth-1:0]  byteLane,
    output logic                          useAr,
    output logic                          memEnable,
    output logic                          memWrite
);

    cpuPkg::stepT                 step;
    cpuPkg::stepT                 nextStep;
    logic [cpuPkg::laneWidth-1:0] writeLane;    // Lane for the store steps

    // ========================================
    // Step register
    // ========================================
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            step <= cpuPkg::stepFetchLow;
        end else begin
            step <= nextStep;
        end
    end

    // Kept apart from the main decode so the forwarded opcode has no loop
    assign decodeLoad = (step == cpuPkg::stepDecode);

    // Exec2 to exec5 map onto byte lanes 0 to 3
    always_comb begin
        case (step)
            cpuPkg::stepExec3: writeLane = 2'd1;
            cpuPkg::stepExec4: writeLane = 2'd2;
            cpuPkg::stepExec5: writeLane = 2'd3;
            default:           writeLane = 2'd0;
        endcase
    end

    // ========================================
    // Strobes and next step
    // ========================================
    always_comb begin
        irLoadLow     = 1'b0;
        irLoadHigh    = 1'b0;
        pcIncrement   = 1'b0;
        regShiftLoad  = 1'b0;
        regLoadData   = 1'b0;
        arLoadAddress = 1'b0;
        arAddOffset   = 1'b0;
        arIncrement   = 1'b0;
        drLoadLow     = 1'b0;
        drLoadHigh    = 1'b0;
        byteLane      = '0;
        useAr         = 1'b0;
        memEnable     = 1'b0;
        memWrite      = 1'b0;
        nextStep      = cpuPkg::stepFetchLow;   // Every instruction ends here

        case (step)
            cpuPkg::stepFetchLow: begin
                memEnable   = 1'b1;             // Read at PC
                irLoadLow   = 1'b1;
                pcIncrement = 1'b1;
                nextStep    = cpuPkg::stepFetchHigh;
            end
            cpuPkg::stepFetchHigh: begin
                memEnable   = 1'b1;
                irLoadHigh  = 1'b1;
                pcIncrement = 1'b1;
                nextStep    = cpuPkg::stepDecode;
            end
            cpuPkg::stepDecode: begin
                case (opcode)
                    cpuPkg::MOVSH, cpuPkg::LDAL, cpuPkg::STA, cpuPkg::STRIM:
                        nextStep = cpuPkg::stepExec1;
                    default:
                        nextStep = cpuPkg::stepFetchLow;  // Unknown opcode is a no-op
                endcase
            end
            default: begin
                case (opcode)
                    cpuPkg::MOVSH: begin
                        regShiftLoad = 1'b1;    // Single execute step
                    end
                    cpuPkg::LDAL: begin
                        if (step == cpuPkg::stepExec1) begin
                            arLoadAddress = 1'b1;
                            nextStep      = cpuPkg::stepExec2;
                        end else begin
                            useAr       = 1'b1;
                            memEnable   = 1'b1;
                            arIncrement = 1'b1;
                            if (step == cpuPkg::stepExec2) begin
                                drLoadLow = 1'b1;
                                nextStep  = cpuPkg::stepExec3;
                            end else begin
                                drLoadHigh  = 1'b1;   // Word completes this step
                                regLoadData = 1'b1;
                            end
                        end
                    end
                    cpuPkg::STA, cpuPkg::STRIM: begin
                        if (step == cpuPkg::stepExec1) begin
                            arLoadAddress = (opcode == cpuPkg::STA);    // Absolute
                            arAddOffset   = (opcode == cpuPkg::STRIM);  // AR relative
                            nextStep      = cpuPkg::stepExec2;
                        end else begin
                            useAr       = 1'b1;
                            memEnable   = 1'b1;
                            memWrite    = 1'b1;
                            arIncrement = 1'b1;
                            byteLane    = writeLane;
                            if (int'(writeLane) != cpuPkg::bytesPerWord - 1) begin
                                nextStep = cpuPkg::stepT'(step + 1'b1);
                            end
                        end
                    end
                    default: begin
                        nextStep = cpuPkg::stepFetchLow;
                    end
                endcase
            end
        endcase
    end

endmodule

// ==== verilog.f ====
+incdir+.
cpuPkg.sv
fetchStage.sv
decodeStage.sv
sequencer.sv
registerFile.sv
addressUnit.sv
cpuTop.sv
cpuTb.sv
